/* hw/enemyLaneFsm.sv */
`default_nettype none

module enemyLaneFsm (
	input wire clk,
	input wire arstN,
	input wire tick,
	input wire radarPkg::enemyTypeT enemyType,
	output radarPkg::stepT laneStep,
	output logic laneDead
);

	radarPkg::laneStateT state;
	radarPkg::laneStateT stateNext;
	radarPkg::stepT stepNext;

	always_comb begin
		stateNext = state;
		stepNext = laneStep;
		if (enemyType == '0) begin
			// Absent enemy clears the lane without waiting for a tick
			stateNext = radarPkg::laneIdle;
			stepNext = '0;
		end else if (tick) begin
			case (state)
				radarPkg::laneIdle: begin
					stateNext = radarPkg::laneMoving;
					stepNext = radarPkg::FIRST_STEP;
				end
				radarPkg::laneMoving: begin
					stepNext = laneStep + 3'd1;
					if (laneStep == radarPkg::LAST_STEP) begin
						stateNext = radarPkg::laneDead; // Reached the ship
					end
				end
				default: begin
					stateNext = state; // Dead until the type goes to zero
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= radarPkg::laneIdle;
			laneStep <= '0;
			laneDead <= 1'b0;
		end else begin
			state <= stateNext;
			laneStep <= stepNext;
			laneDead <= (stateNext == radarPkg::laneDead);
		end
	end

	// Step 7 exactly in the dead state
	deadAgree: assert property (@(posedge clk) disable iff (!arstN)
		(laneStep == radarPkg::DEAD_STEP) == (state == radarPkg::laneDead));

	// Movement only on a tick, clearing excepted
	stepOnTick: assert property (@(posedge clk) disable iff (!arstN)
		!tick |=> ($stable(laneStep) || laneStep == '0));

endmodule

`default_nettype wire

/* hw/pixelCompositor.sv */
`default_nettype none

module pixelCompositor (
	input wire clk,
	input wire arstN,
	input wire radarPkg::coordT x,
	input wire radarPkg::coordT y,
	input wire spriteHit,
	input wire radarPkg::enemyTypeT spriteType,
	input wire laneDead0,
	input wire laneDead1,
	input wire laneDead2,
	input wire laneDead3,
	output radarPkg::colorT red,
	output radarPkg::colorT green,
	output radarPkg::colorT blue
);

	logic shipHit;
	logic lineHit;
	logic anyDead;
	radarPkg::rgbT pixelColor;

	// Ship square is inclusive on all four edges
	assign shipHit = (x >= radarPkg::CENTER_X - radarPkg::SHIP_HALF) &&
		(x <= radarPkg::CENTER_X + radarPkg::SHIP_HALF) &&
		(y >= radarPkg::CENTER_Y - radarPkg::SHIP_HALF) &&
		(y <= radarPkg::CENTER_Y + radarPkg::SHIP_HALF);

	assign lineHit = (x == radarPkg::CENTER_X) || (y == radarPkg::CENTER_Y);

	assign anyDead = laneDead0 | laneDead1 | laneDead2 | laneDead3;

	always_comb begin
		if (shipHit) begin
			pixelColor = radarPkg::SHIP_COLOR;
		end else if (lineHit) begin
			pixelColor = radarPkg::LINE_COLOR;
		end else if (spriteHit) begin
			pixelColor = radarPkg::ENEMY_COLOR[spriteType];
		end else if (anyDead) begin
			pixelColor = radarPkg::DEAD_COLOR; // Enemy got through
		end else begin
			pixelColor = radarPkg::BACK_COLOR;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			red <= pixelColor[23:16];
			green <= pixelColor[15:8];
			blue <= pixelColor[7:0];
		end
	end

	// Locator only reports lanes that hold an enemy
	hitHasType: assert property (@(posedge clk) disable iff (!arstN)
		spriteHit |-> (spriteType != '0));

endmodule

`default_nettype wire

/* hw/radarPkg.sv */
`default_nettype none

package radarPkg;

	typedef logic [9:0] coordT; // Pixel coordinate on either axis
	typedef logic [7:0] colorT;
	typedef logic [23:0] rgbT; // Red, green, blue channels packed
	typedef logic [1:0] enemyTypeT; // 0 absent, 1 red, 2 blue, 3 green
	typedef logic [2:0] stepT; // 0 idle, 1..6 on screen, 7 at ship
	typedef logic [1:0] laneIdxT;

	typedef enum logic [1:0] {
		laneIdle,
		laneMoving,
		laneDead
	} laneStateT;

	parameter int NUM_LANES = 4;

	parameter stepT FIRST_STEP = 3'd1;
	parameter stepT LAST_STEP = 3'd6; // Last step with a visible sprite
	parameter stepT DEAD_STEP = 3'd7;

	// Screen geometry, 640x480
	parameter coordT CENTER_X = 10'd320;
	parameter coordT CENTER_Y = 10'd240;
	parameter coordT SHIP_HALF = 10'd16;
	parameter coordT SPRITE_SIZE = 10'd10;

	parameter rgbT SHIP_COLOR = 24'hf518c9;
	parameter rgbT LINE_COLOR = 24'h808080;
	parameter rgbT DEAD_COLOR = 24'h000000;
	parameter rgbT BACK_COLOR = 24'hffffff;

	// Red, blue, green by enemy type
	parameter rgbT ENEMY_COLOR [1:3] = '{24'hff0000, 24'h0000ff, 24'h00ff00};

	// Top left corner of each sprite, lanes right, top, left, bottom
	parameter coordT spriteOriginX [NUM_LANES][1:6] = '{
		'{10'd620, 10'd570, 10'd520, 10'd470, 10'd420, 10'd370},
		'{10'd315, 10'd315, 10'd315, 10'd315, 10'd315, 10'd315},
		'{10'd10, 10'd54, 10'd107, 10'd160, 10'd214, 10'd267},
		'{10'd315, 10'd315, 10'd315, 10'd315, 10'd315, 10'd315}
	};

	parameter coordT spriteOriginY [NUM_LANES][1:6] = '{
		'{10'd235, 10'd235, 10'd235, 10'd235, 10'd235, 10'd235},
		'{10'd10, 10'd40, 10'd80, 10'd120, 10'd160, 10'd200},
		'{10'd235, 10'd235, 10'd235, 10'd235, 10'd235, 10'd235},
		'{10'd460, 10'd420, 10'd380, 10'd340, 10'd300, 10'd260}
	};

endpackage

`default_nettype wire

/* hw/radarScreen.sv */
`default_nettype none

module radarScreen #(
	parameter int TICK_CYCLES = 25_000_000
) (
	input wire clk,
	input wire arstN,
	input wire radarPkg::coordT x,
	input wire radarPkg::coordT y,
	input wire radarPkg::enemyTypeT enemyType0,
	input wire radarPkg::enemyTypeT enemyType1,
	input wire radarPkg::enemyTypeT enemyType2,
	input wire radarPkg::enemyTypeT enemyType3,
	output radarPkg::colorT red,
	output radarPkg::colorT green,
	output radarPkg::colorT blue
);

	logic tick;
	radarPkg::enemyTypeT laneType [radarPkg::NUM_LANES];
	radarPkg::stepT laneStep [radarPkg::NUM_LANES];
	logic laneDead [radarPkg::NUM_LANES];
	logic spriteHit;
	radarPkg::enemyTypeT spriteType;

	assign laneType = '{enemyType0, enemyType1, enemyType2, enemyType3};

	tickTimer #(
		.TICK_CYCLES(TICK_CYCLES)
	) tickTimer_i (
		.clk(clk),
		.arstN(arstN),
		.tick(tick)
	);

	// Lanes 0..3 are right, top, left, bottom
	for (genvar i = 0; i < radarPkg::NUM_LANES; i++) begin : genLane
		enemyLaneFsm enemyLaneFsm_i (
			.clk(clk),
			.arstN(arstN),
			.tick(tick),
			.enemyType(laneType[i]),
			.laneStep(laneStep[i]),
			.laneDead(laneDead[i])
		);
	end

	spriteLocator spriteLocator_i (
		.x(x),
		.y(y),
		.laneStep0(laneStep[0]),
		.laneStep1(laneStep[1]),
		.laneStep2(laneStep[2]),
		.laneStep3(laneStep[3]),
		.enemyType0(enemyType0),
		.enemyType1(enemyType1),
		.enemyType2(enemyType2),
		.enemyType3(enemyType3),
		.spriteHit(spriteHit),
		.spriteType(spriteType)
	);

	pixelCompositor pixelCompositor_i (
		.clk(clk),
		.arstN(arstN),
		.x(x),
		.y(y),
		.spriteHit(spriteHit),
		.spriteType(spriteType),
		.laneDead0(laneDead[0]),
		.laneDead1(laneDead[1]),
		.laneDead2(laneDead[2]),
		.laneDead3(laneDead[3]),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

`default_nettype wire

/* hw/spriteLocator.sv */
`default_nettype none

module spriteLocator (
	input wire radarPkg::coordT x,
	input wire radarPkg::coordT y,
	input wire radarPkg::stepT laneStep0,
	input wire radarPkg::stepT laneStep1,
	input wire radarPkg::stepT laneStep2,
	input wire radarPkg::stepT laneStep3,
	input wire radarPkg::enemyTypeT enemyType0,
	input wire radarPkg::enemyTypeT enemyType1,
	input wire radarPkg::enemyTypeT enemyType2,
	input wire radarPkg::enemyTypeT enemyType3,
	output logic spriteHit,
	output radarPkg::enemyTypeT spriteType
);

	radarPkg::stepT steps [radarPkg::NUM_LANES];
	radarPkg::enemyTypeT types [radarPkg::NUM_LANES];
	logic [radarPkg::NUM_LANES-1:0] laneHit;
	radarPkg::laneIdxT winLane;

	assign steps = '{laneStep0, laneStep1, laneStep2, laneStep3};
	assign types = '{enemyType0, enemyType1, enemyType2, enemyType3};

	for (genvar i = 0; i < radarPkg::NUM_LANES; i++) begin : genBox
		logic onScreen;
		radarPkg::stepT tableStep;
		radarPkg::coordT originX;
		radarPkg::coordT originY;

		assign onScreen = (steps[i] >= radarPkg::FIRST_STEP) &&
			(steps[i] <= radarPkg::LAST_STEP) && (types[i] != '0);
		// Keep the table index in range while the lane is off screen
		assign tableStep = onScreen ? steps[i] : radarPkg::FIRST_STEP;
		assign originX = radarPkg::spriteOriginX[i][tableStep];
		assign originY = radarPkg::spriteOriginY[i][tableStep];

		assign laneHit[i] = onScreen &&
			(x >= originX) && (x <= originX + radarPkg::SPRITE_SIZE) &&
			(y >= originY) && (y <= originY + radarPkg::SPRITE_SIZE);
	end

	// Scan downward so the lowest hitting lane is left standing
	always_comb begin
		spriteHit = 1'b0;
		winLane = '0;
		for (int i = radarPkg::NUM_LANES - 1; i >= 0; i--) begin
			if (laneHit[i]) begin
				spriteHit = 1'b1;
				winLane = radarPkg::laneIdxT'(i);
			end
		end
	end

	assign spriteType = types[winLane];

endmodule

`default_nettype wire

/* hw/tickTimer.sv */
`default_nettype none

module tickTimer #(
	parameter int TICK_CYCLES = 25_000_000
) (
	input wire clk,
	input wire arstN,
	output logic tick
);

	localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
	localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(TICK_CYCLES - 1);

	logic [CNT_W-1:0] count;
	logic wrap;

	assign wrap = (count == LAST_COUNT);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
			tick <= 1'b0;
		end else begin
			if (wrap) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
			tick <= wrap; // One cycle pulse per wrap
		end
	end

	// Pulses stay isolated unless the period is a single cycle
	tickSingle: assert property (@(posedge clk) disable iff (!arstN)
		(TICK_CYCLES > 1 && tick) |=> !tick);

endmodule

`default_nettype wire

/* project.f */
+incdir+testbench
hw/radarPkg.sv
hw/tickTimer.sv
hw/enemyLaneFsm.sv
hw/spriteLocator.sv
hw/pixelCompositor.sv
hw/radarScreen.sv
testbench/radarScreenTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the radar screen testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	-f project.f \
	--top-module radarScreenTb \
	-o radarScreenSim

./obj_dir/radarScreenSim

/* testbench/radarScreenTable.svh */
`ifndef RADAR_SCREEN_TABLE_SVH
`define RADAR_SCREEN_TABLE_SVH

typedef struct packed {
	logic [1:0] type0;
	logic [1:0] type1;
	logic [1:0] type2;
	logic [1:0] type3;
	logic [7:0] waitCycles;
	logic [9:0] probeX;
	logic [9:0] probeY;
	logic [23:0] rgb;
} stimRowT;

localparam logic [23:0] SHIP_RGB = 24'hf518c9;
localparam logic [23:0] LINE_RGB = 24'h808080;
localparam logic [23:0] DEAD_RGB = 24'h000000;
localparam logic [23:0] BACK_RGB = 24'hffffff;
localparam logic [23:0] RED_RGB = 24'hff0000;
localparam logic [23:0] BLUE_RGB = 24'h0000ff;
localparam logic [23:0] GREEN_RGB = 24'h00ff00;

localparam logic [9:0] RND = 10'h3ff; // Probe a random background pixel

// Sprite top left corners for steps 1..6, lanes right, top, left, bottom
localparam int ORIGIN_X [4][6] = '{
	'{620, 570, 520, 470, 420, 370},
	'{315, 315, 315, 315, 315, 315},
	'{10, 54, 107, 160, 214, 267},
	'{315, 315, 315, 315, 315, 315}
};
localparam int ORIGIN_Y [4][6] = '{
	'{235, 235, 235, 235, 235, 235},
	'{10, 40, 80, 120, 160, 200},
	'{235, 235, 235, 235, 235, 235},
	'{460, 420, 380, 340, 300, 260}
};

localparam int NUM_ROWS = 39;

// Types of lanes 0..3, cycles to wait, probe x, probe y, expected rgb
localparam stimRowT STIM [NUM_ROWS] = '{
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd320, 10'd240, SHIP_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd304, 10'd224, SHIP_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd336, 10'd256, SHIP_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd320, 10'd100, LINE_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd500, 10'd240, LINE_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd303, 10'd240, LINE_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, RND, 10'd0, BACK_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, RND, 10'd0, BACK_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd337, 10'd250, BACK_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd8, 10'd625, 10'd238, RED_RGB}, // Lane 0 step 1
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd0, 10'd625, 10'd240, LINE_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd5, 10'd575, 10'd238, BACK_RGB}, // Still step 1
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd0, 10'd575, 10'd238, RED_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd0, 10'd625, 10'd238, BACK_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd6, 10'd525, 10'd243, RED_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd7, 10'd475, 10'd237, RED_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd0, 10'd525, 10'd243, BACK_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd6, 10'd425, 10'd244, RED_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd7, 10'd375, 10'd236, RED_RGB}, // Step 6
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd0, 10'd425, 10'd244, BACK_RGB},
	'{2'd1, 2'd0, 2'd0, 2'd0, 8'd0, 10'd336, 10'd245, SHIP_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd375, 10'd236, BACK_RGB}, // Cleared
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd4, 10'd625, 10'd238, BLUE_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, 10'd318, 10'd15, GREEN_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, 10'd15, 10'd237, RED_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, 10'd322, 10'd465, BLUE_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd12, 10'd110, 10'd236, RED_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd23, 10'd318, 10'd265, BLUE_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, 10'd320, 10'd256, SHIP_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, RND, 10'd0, BACK_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd5, RND, 10'd0, DEAD_RGB}, // All lanes at ship
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, 10'd310, 10'd230, SHIP_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, 10'd100, 10'd240, LINE_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, 10'd320, 10'd400, LINE_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd20, RND, 10'd0, DEAD_RGB},
	'{2'd2, 2'd3, 2'd1, 2'd2, 8'd0, 10'd318, 10'd265, DEAD_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, RND, 10'd0, DEAD_RGB}, // Clears at next edge
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, RND, 10'd0, BACK_RGB},
	'{2'd0, 2'd0, 2'd0, 2'd0, 8'd0, 10'd320, 10'd240, SHIP_RGB}
};

`endif

/* testbench/radarScreenTb.sv */
`default_nettype none

module radarScreenTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TICK_CYCLES = 8;

	`include "radarScreenTable.svh"

	logic clk = 1'b0;
	logic arstN;
	logic [9:0] x;
	logic [9:0] y;
	logic [1:0] typeIn [4];
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	int modelStep [4]; // Reckoned from the tick count
	int cycleCount;
	int runCycles = 0;
	int timeoutLimit;

	radarScreen #(
		.TICK_CYCLES(TICK_CYCLES)
	) radarScreen_i (
		.clk(clk),
		.arstN(arstN),
		.x(x),
		.y(y),
		.enemyType0(typeIn[0]),
		.enemyType1(typeIn[1]),
		.enemyType2(typeIn[2]),
		.enemyType3(typeIn[3]),
		.red(red),
		.green(green),
		.blue(blue)
	);

	always #50 clk = ~clk;

	// Tick in the cycle after every multiple of TICK_CYCLES edges
	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cycleCount <= 0;
			for (int i = 0; i < 4; i++) begin
				modelStep[i] <= 0;
			end
		end else begin
			cycleCount <= cycleCount + 1;
			for (int i = 0; i < 4; i++) begin
				if (typeIn[i] == 2'd0) begin
					modelStep[i] <= 0;
				end else if (cycleCount > 0 && cycleCount % TICK_CYCLES == 0 &&
					modelStep[i] < 7) begin
					modelStep[i] <= modelStep[i] + 1; // Step 7 holds
				end
			end
		end
	end

	always @(posedge clk) begin
		runCycles <= runCycles + 1;
		if (runCycles >= timeoutLimit) begin
			$display("Timeout: the run went past %0d cycles without finishing", timeoutLimit);
			$display("sim failed");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [23:0] actual,
		input logic [23:0] expected);
		if (actual !== expected) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	function automatic bit inShip(int px, int py);
		return px >= 304 && px <= 336 && py >= 224 && py <= 256;
	endfunction

	// Lowest lane whose visible sprite covers the pixel, or -1
	function automatic int spriteLane(int px, int py);
		int ox;
		int oy;
		for (int i = 0; i < 4; i++) begin
			if (modelStep[i] >= 1 && modelStep[i] <= 6 && typeIn[i] != 2'd0) begin
				ox = ORIGIN_X[i][modelStep[i] - 1];
				oy = ORIGIN_Y[i][modelStep[i] - 1];
				if (px >= ox && px <= ox + 10 && py >= oy && py <= oy + 10) begin
					return i;
				end
			end
		end
		return -1;
	endfunction

	function automatic logic [23:0] typeRgb(logic [1:0] kind);
		case (kind)
			2'd1: return RED_RGB;
			2'd2: return BLUE_RGB;
			2'd3: return GREEN_RGB;
			default: return BACK_RGB;
		endcase
	endfunction

	function automatic logic [23:0] modelColor(int px, int py);
		int lane;
		bit anyDead;
		lane = spriteLane(px, py);
		anyDead = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (modelStep[i] == 7) begin
				anyDead = 1'b1;
			end
		end
		if (inShip(px, py)) begin
			return SHIP_RGB;
		end
		if (px == 320 || py == 240) begin
			return LINE_RGB;
		end
		if (lane >= 0) begin
			return typeRgb(typeIn[lane]);
		end
		return anyDead ? DEAD_RGB : BACK_RGB;
	endfunction

	task automatic pickBackground(output int px, output int py);
		bit found;
		found = 1'b0;
		for (int t = 0; t < 100 && !found; t++) begin
			px = int'($urandom % 640);
			py = int'($urandom % 480);
			found = !inShip(px, py) && px != 320 && py != 240 && spriteLane(px, py) < 0;
		end
		if (!found) begin
			$display("No background pixel found for a random probe");
			$display("sim failed");
			$fatal(1);
		end
	endtask

	initial begin
		int px;
		int py;
		logic [23:0] expectRgb;
		void'($urandom(32'hd371));
		timeoutLimit = 64;
		for (int r = 0; r < NUM_ROWS; r++) begin
			timeoutLimit += int'(STIM[r].waitCycles) + 4;
		end
		arstN = 1'b0;
		x = '0;
		y = '0;
		for (int i = 0; i < 4; i++) begin
			typeIn[i] = 2'd0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			typeIn[0] = STIM[r].type0;
			typeIn[1] = STIM[r].type1;
			typeIn[2] = STIM[r].type2;
			typeIn[3] = STIM[r].type3;
			repeat (int'(STIM[r].waitCycles)) @(negedge clk);
			if (STIM[r].probeX == RND) begin
				pickBackground(px, py);
			end else begin
				px = int'(STIM[r].probeX);
				py = int'(STIM[r].probeY);
			end
			x = 10'(px);
			y = 10'(py);
			// Lane state of the probe cycle is what the colour reflects
			expectRgb = modelColor(px, py);
			checkValue($sformatf("row %0d table rgb", r), STIM[r].rgb, expectRgb);
			@(posedge clk);
			@(negedge clk);
			checkValue("red", 24'(red), 24'(expectRgb[23:16]));
			checkValue("green", 24'(green), 24'(expectRgb[15:8]));
			checkValue("blue", 24'(blue), 24'(expectRgb[7:0]));
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
